// File: Bender.yml
package:
  name: blit_state

export_include_dirs:
  - .

sources:
  - blit_pkg.sv
  - blit_regs.sv
  - blit_outer.sv
  - blit_inner.sv
  - blit_mcontrol.sv
  - blit_state.sv
  - target: test
    files:
      - blit_properties.sv
      - blit_checker.sv
      - tb_blit.sv

// File: blit_cfg.svh
`ifndef BLIT_CFG_SVH
`define BLIT_CFG_SVH

// Datapath widths
`define BLIT_ADDR_W 24 // Memory address
`define BLIT_DATA_W 32 // Memory data and registers
`define BLIT_COUNT_W 16 // Loop counters and pitch
`define BLIT_LFU_W 4 // Logic function truth table
`define BLIT_REG_AW 8 // AXI4-Lite register address

// Register map, byte offsets
`define BLIT_REG_SRC 8'h00
`define BLIT_REG_DST 8'h04
`define BLIT_REG_PITCH 8'h08 // Row pitch in words
`define BLIT_REG_COUNT 8'h0C // Outer count high, inner count low
`define BLIT_REG_CMD 8'h10 // Write starts a blit
`define BLIT_REG_STATUS 8'h14

// Command word bits
`define BLIT_CMD_SRCEN 0
`define BLIT_CMD_DSTEN 1
`define BLIT_CMD_LFU_LSB 21

// Status word bits
`define BLIT_STAT_IDLE 0
`define BLIT_STAT_INT 1

// AXI response codes
`define BLIT_RESP_OKAY 2'b00
`define BLIT_RESP_SLVERR 2'b10

`endif

// File: blit_checker.sv
`timescale 1ns/100ps
`include "blit_cfg.svh"

module blit_checker (
	input logic clk,
	input logic rst_n,
	input logic [7:0] test_id,
	input logic [`BLIT_REG_AW-1:0] s_awaddr,
	input logic s_awvalid,
	input logic s_awready,
	input logic [`BLIT_DATA_W-1:0] s_wdata,
	input logic s_wvalid,
	input logic s_wready,
	input logic [1:0] s_bresp,
	input logic s_bvalid,
	input logic s_bready,
	input logic [`BLIT_REG_AW-1:0] s_araddr,
	input logic s_arvalid,
	input logic s_arready,
	input logic [`BLIT_DATA_W-1:0] s_rdata,
	input logic [1:0] s_rresp,
	input logic s_rvalid,
	input logic s_rready,
	input logic mreq,
	input blit_pkg::blit_cycle_t mem,
	input logic ack,
	input logic blit_int,
	output int err_count,
	output int check_count,
	output int exp_left
);
	import blit_pkg::*;

	localparam logic [31:0] CMD_MASK = (32'hf << `BLIT_CMD_LFU_LSB) | 32'h3;

	blit_cycle_t exp_q[$]; // Cycles still owed by the current blit
	blit_cycle_t exp_c;
	logic [31:0] src_sh;
	logic [31:0] dst_sh;
	logic [31:0] pitch_sh;
	logic [31:0] count_sh;
	logic [31:0] cmd_sh;
	logic [31:0] exp_rdata;
	logic [1:0] exp_bresp;
	logic exp_int;
	int n_cycles;
	int int_wait; // Edges left until the interrupt must show

	function automatic string test_label(input logic [7:0] id);
		case (id)
			8'd1: return "readback";
			8'd2: return "copy";
			8'd3: return "xor_rmw";
			8'd4: return "completion";
			8'd5: return "zero_count";
			default: return "reset";
		endcase
	endfunction

	function automatic logic [`BLIT_DATA_W-1:0] fill_word(input logic [`BLIT_ADDR_W-1:0] addr);
		return {addr[7:0] ^ addr[23:16], addr} ^ 32'h5a3c_96e1;
	endfunction

	// Truth table lookup at index 2*s + d for every bit
	function automatic logic [31:0] lfu_ref(input logic [3:0] func, input logic [31:0] s,
			input logic [31:0] d);
		logic [31:0] r;
		int idx;
		for (int i = 0; i < 32; i++) begin
			idx = 2 * s[i] + d[i];
			r[i] = func[idx];
		end
		return r;
	endfunction

	// Expected cycles of one blit in row and pixel order
	function automatic int build_cycles(input logic [31:0] cmd_word);
		blit_cycle_t c;
		logic [`BLIT_ADDR_W-1:0] srow;
		logic [`BLIT_ADDR_W-1:0] drow;
		logic [31:0] sd;
		logic [31:0] dd;
		logic srcen;
		logic dsten;
		srcen = cmd_word[`BLIT_CMD_SRCEN];
		dsten = cmd_word[`BLIT_CMD_DSTEN];
		for (int r = 0; r < int'(count_sh[31:16]); r++) begin
			srow = src_sh[23:0] + `BLIT_ADDR_W'(r * 4 * pitch_sh[15:0]);
			drow = dst_sh[23:0] + `BLIT_ADDR_W'(r * 4 * pitch_sh[15:0]);
			for (int p = 0; p < int'(count_sh[15:0]); p++) begin
				c.rd = 1'b1;
				c.wdata = '0;
				c.addr = srow + `BLIT_ADDR_W'(p * 4);
				sd = srcen ? fill_word(c.addr) : '0;
				if (srcen)
					exp_q.push_back(c);
				c.addr = drow + `BLIT_ADDR_W'(p * 4);
				dd = dsten ? fill_word(c.addr) : '0;
				if (dsten)
					exp_q.push_back(c);
				c.rd = 1'b0;
				c.wdata = lfu_ref(cmd_word[`BLIT_CMD_LFU_LSB +: `BLIT_LFU_W], sd, dd);
				exp_q.push_back(c);
			end
		end
		return exp_q.size();
	endfunction

	function automatic logic [31:0] expected_read(input logic [`BLIT_REG_AW-1:0] addr);
		logic [31:0] r;
		r = '0;
		case (addr)
			`BLIT_REG_SRC: r = src_sh;
			`BLIT_REG_DST: r = dst_sh;
			`BLIT_REG_PITCH: r = pitch_sh;
			`BLIT_REG_COUNT: r = count_sh;
			`BLIT_REG_CMD: r = cmd_sh;
			`BLIT_REG_STATUS: begin
				r[`BLIT_STAT_IDLE] = (exp_q.size() == 0);
				r[`BLIT_STAT_INT] = exp_int;
			end
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic compare_value(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		check_count++;
		if (expected !== actual) begin
			$display("error %s %s expected %0h actual %0h", test_label(test_id), what,
				expected, actual);
			err_count++;
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			exp_q.delete();
			exp_int = 1'b0;
			int_wait = 0;
			cmd_sh = '0;
			exp_bresp = `BLIT_RESP_OKAY;
		end else begin
			if (blit_int && !exp_int) begin
				$display("%s: interrupt raised before the blit completed",
					test_label(test_id));
				err_count++;
			end
			if (int_wait > 0) begin
				int_wait--;
				if (int_wait == 0)
					compare_value("interrupt", 1'b1, blit_int);
			end
			if (s_rvalid && s_rready) begin
				compare_value("read data", exp_rdata, s_rdata);
				compare_value("read response", `BLIT_RESP_OKAY, s_rresp);
			end
			if (s_arvalid && s_arready)
				exp_rdata = expected_read(s_araddr); // State before this edge
			if (s_bvalid && s_bready)
				compare_value("write response", exp_bresp, s_bresp);
			if (s_awvalid && s_awready && s_wvalid && s_wready) begin
				exp_bresp = `BLIT_RESP_OKAY;
				case (s_awaddr)
					`BLIT_REG_SRC: src_sh = s_wdata;
					`BLIT_REG_DST: dst_sh = s_wdata;
					`BLIT_REG_PITCH: pitch_sh = s_wdata;
					`BLIT_REG_COUNT: count_sh = s_wdata;
					`BLIT_REG_CMD: begin
						if (exp_q.size() != 0) begin
							exp_bresp = `BLIT_RESP_SLVERR; // Busy, command ignored
						end else begin
							cmd_sh = s_wdata & CMD_MASK;
							n_cycles = build_cycles(s_wdata);
							exp_int = (n_cycles == 0); // Empty blit completes at once
						end
					end
					default: ;
				endcase
			end
			if (mreq && ack) begin
				if (exp_q.size() == 0) begin
					$display("%s: memory cycle to address %0h arrived with none expected",
						test_label(test_id), mem.addr);
					err_count++;
				end else begin
					exp_c = exp_q.pop_front();
					compare_value("cycle type", exp_c.rd, mem.rd);
					compare_value("cycle address", exp_c.addr, mem.addr);
					if (!exp_c.rd)
						compare_value("write data", exp_c.wdata, mem.wdata);
					if (exp_q.size() == 0) begin
						exp_int = 1'b1;
						int_wait = 3; // Set two cycles after this ack, seen one edge later
					end
				end
			end
			exp_left = exp_q.size();
		end
	end

endmodule

// File: blit_inner.sv
`timescale 1ns/100ps
`include "blit_cfg.svh"

module blit_inner (
	input logic clk,
	input logic rst_n,
	input blit_pkg::blit_cmd_t cmd,
	input logic row_start,
	input blit_pkg::blit_row_t row,
	output logic row_done,
	output logic cyc_valid,
	output blit_pkg::blit_cycle_t cyc,
	input logic cyc_done,
	input logic [`BLIT_DATA_W-1:0] cyc_rdata
);
	import blit_pkg::*;

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_SRC, // Source read
		PH_DST, // Destination read
		PH_WR // Destination write
	} phase_t;

	phase_t phase_q;
	phase_t first_phase;
	blit_row_t row_q;
	logic [`BLIT_COUNT_W-1:0] pix_q;
	logic [`BLIT_DATA_W-1:0] src_q;
	logic [`BLIT_DATA_W-1:0] dst_q;
	logic [`BLIT_DATA_W-1:0] s_bits;
	logic [`BLIT_DATA_W-1:0] d_bits;
	logic [`BLIT_DATA_W-1:0] lfu_out;
	logic [`BLIT_ADDR_W-1:0] pix_off;
	logic last_pix;

	assign first_phase = cmd.srcen ? PH_SRC : (cmd.dsten ? PH_DST : PH_WR);
	assign last_pix = (pix_q == cmd.inner_cnt - 1'b1);
	assign pix_off = `BLIT_ADDR_W'({pix_q, 2'b00}); // One word per pixel
	assign s_bits = cmd.srcen ? src_q : '0;
	assign d_bits = cmd.dsten ? dst_q : '0;
	assign cyc_valid = (phase_q != PH_IDLE);
	assign row_done = cyc_done & (phase_q == PH_WR) & last_pix;

	// Logic function unit, one truth table lookup per bit
	always_comb begin
		for (int i = 0; i < `BLIT_DATA_W; i++) begin
			lfu_out[i] = cmd.lfu_func[{s_bits[i], d_bits[i]}];
		end
	end

	// Held unchanged until cyc_done since it only follows registers
	always_comb begin
		cyc.rd = (phase_q != PH_WR);
		cyc.addr = ((phase_q == PH_SRC) ? row_q.src_addr : row_q.dst_addr) + pix_off;
		cyc.wdata = (phase_q == PH_WR) ? lfu_out : '0;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase_q <= PH_IDLE;
		end else if (row_start) begin
			phase_q <= first_phase;
		end else if (cyc_done) begin
			case (phase_q)
				PH_SRC: phase_q <= cmd.dsten ? PH_DST : PH_WR;
				PH_DST: phase_q <= PH_WR;
				PH_WR: phase_q <= last_pix ? PH_IDLE : first_phase;
				default: phase_q <= PH_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (row_start) begin
			row_q <= row;
			pix_q <= '0;
		end else if (cyc_done & (phase_q == PH_WR)) begin
			pix_q <= pix_q + 1'b1;
		end
		if (cyc_done & (phase_q == PH_SRC))
			src_q <= cyc_rdata;
		if (cyc_done & (phase_q == PH_DST))
			dst_q <= cyc_rdata;
	end

endmodule

// File: blit_mcontrol.sv
`timescale 1ns/100ps
`include "blit_cfg.svh"

module blit_mcontrol (
	input logic clk,
	input logic rst_n,
	input logic cyc_valid,
	input blit_pkg::blit_cycle_t cyc,
	output logic cyc_done,
	output logic [`BLIT_DATA_W-1:0] cyc_rdata,
	output logic mreq,
	output blit_pkg::blit_cycle_t mem,
	input logic ack,
	input logic [`BLIT_DATA_W-1:0] rdata
);
	logic issue;
	logic finish;

	// cyc_valid is still high in the cyc_done cycle, so that cycle must not issue
	assign issue = cyc_valid & ~mreq & ~cyc_done;
	assign finish = mreq & ack;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mreq <= 1'b0;
			cyc_done <= 1'b0;
		end else begin
			cyc_done <= finish;
			if (finish)
				mreq <= 1'b0;
			else if (issue)
				mreq <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (issue)
			mem <= cyc; // Stays put until ack
		if (finish & mem.rd)
			cyc_rdata <= rdata; // Read data valid with ack
	end

endmodule

// File: blit_outer.sv
`timescale 1ns/100ps
`include "blit_cfg.svh"

module blit_outer (
	input logic clk,
	input logic rst_n,
	input blit_pkg::blit_cmd_t cmd,
	input logic start,
	output logic busy,
	output logic done,
	output logic row_start,
	output blit_pkg::blit_row_t row,
	input logic row_done
);
	logic [`BLIT_COUNT_W-1:0] rows_left;
	logic [`BLIT_ADDR_W-1:0] row_step;
	logic last_row;

	// Pitch is in words, addresses in bytes
	assign row_step = `BLIT_ADDR_W'({cmd.pitch, 2'b00});
	assign last_row = (rows_left == `BLIT_COUNT_W'(1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			row_start <= 1'b0;
		end else begin
			row_start <= start | (row_done & ~last_row);
			done <= row_done & last_row;
			if (start)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0; // Drops together with the interrupt
		end
	end

	// Row address walk, wraps at the address width
	always_ff @(posedge clk) begin
		if (start) begin
			rows_left <= cmd.outer_cnt;
			row.src_addr <= cmd.src_base;
			row.dst_addr <= cmd.dst_base;
		end else if (row_done) begin
			rows_left <= rows_left - 1'b1;
			row.src_addr <= row.src_addr + row_step;
			row.dst_addr <= row.dst_addr + row_step;
		end
	end

endmodule

// File: blit_pkg.sv
`include "blit_cfg.svh"

package blit_pkg;

	// Command as latched from the register block
	typedef struct packed {
		logic srcen; // Read source per pixel
		logic dsten; // Read destination per pixel
		logic [`BLIT_LFU_W-1:0] lfu_func; // Indexed by {src, dst}
		logic [`BLIT_ADDR_W-1:0] src_base;
		logic [`BLIT_ADDR_W-1:0] dst_base;
		logic [`BLIT_COUNT_W-1:0] pitch; // In words
		logic [`BLIT_COUNT_W-1:0] inner_cnt; // Pixels per row
		logic [`BLIT_COUNT_W-1:0] outer_cnt; // Rows
	} blit_cmd_t;

	// Start addresses of one row
	typedef struct packed {
		logic [`BLIT_ADDR_W-1:0] src_addr;
		logic [`BLIT_ADDR_W-1:0] dst_addr;
	} blit_row_t;

	// One memory cycle, read or write
	typedef struct packed {
		logic rd; // 1 for read, 0 for write
		logic [`BLIT_ADDR_W-1:0] addr;
		logic [`BLIT_DATA_W-1:0] wdata; // Only meaningful on writes
	} blit_cycle_t;

endpackage

// File: blit_properties.sv
`timescale 1ns/100ps

module blit_properties (
	input logic clk,
	input logic rst_n,
	input logic mreq,
	input blit_pkg::blit_cycle_t mem,
	input logic ack,
	input logic blit_int,
	input logic s_bvalid,
	input logic s_bready,
	input logic [1:0] s_bresp
);
	mem_held: assert property (@(posedge clk) disable iff (!rst_n)
		mreq && !ack |=> mreq && $stable(mem))
		else $error("memory request dropped or changed before ack");

	ack_with_req: assert property (@(posedge clk) disable iff (!rst_n) ack |-> mreq)
		else $error("memory ack seen without a request");

	int_after_reset: assert property (@(posedge clk) !rst_n |=> !blit_int)
		else $error("interrupt high after reset");

	bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
		s_bvalid && !s_bready |=> s_bvalid && $stable(s_bresp))
		else $error("write response dropped or changed before BREADY");

endmodule

bind blit_state blit_properties props_i (.*);

// File: blit_regs.sv
`timescale 1ns/100ps
`include "blit_cfg.svh"

module blit_regs (
	input logic clk,
	input logic rst_n,
	input logic [`BLIT_REG_AW-1:0] s_awaddr,
	input logic s_awvalid,
	output logic s_awready,
	input logic [`BLIT_DATA_W-1:0] s_wdata,
	input logic [`BLIT_DATA_W/8-1:0] s_wstrb,
	input logic s_wvalid,
	output logic s_wready,
	output logic [1:0] s_bresp,
	output logic s_bvalid,
	input logic s_bready,
	input logic [`BLIT_REG_AW-1:0] s_araddr,
	input logic s_arvalid,
	output logic s_arready,
	output logic [`BLIT_DATA_W-1:0] s_rdata,
	output logic [1:0] s_rresp,
	output logic s_rvalid,
	input logic s_rready,
	output blit_pkg::blit_cmd_t cmd,
	output logic start,
	input logic busy,
	input logic done,
	output logic blit_int
);
	logic [`BLIT_DATA_W-1:0] src_q;
	logic [`BLIT_DATA_W-1:0] dst_q;
	logic [`BLIT_DATA_W-1:0] pitch_q;
	logic [`BLIT_DATA_W-1:0] count_q;
	logic [`BLIT_DATA_W-1:0] wmask;
	logic [`BLIT_DATA_W-1:0] wval;
	logic [`BLIT_DATA_W-1:0] rd_mux;
	logic aw_hs;
	logic ar_hs;
	logic wr_cmd;
	logic active;
	logic cmd_go;
	logic count_zero;
	logic zero_done;

	function automatic logic [`BLIT_DATA_W-1:0] merge(input logic [`BLIT_DATA_W-1:0] old_v,
			input logic [`BLIT_DATA_W-1:0] new_v, input logic [`BLIT_DATA_W-1:0] mask);
		return (old_v & ~mask) | (new_v & mask);
	endfunction

	assign s_awready = s_wvalid & ~s_bvalid; // AW and W taken together
	assign s_wready = s_awvalid & ~s_bvalid;
	assign s_arready = ~s_rvalid;
	assign s_rresp = `BLIT_RESP_OKAY;
	assign aw_hs = s_awvalid & s_wvalid & ~s_bvalid;
	assign ar_hs = s_arvalid & ~s_rvalid;

	assign wr_cmd = aw_hs & (s_awaddr == `BLIT_REG_CMD);
	assign active = busy | start; // Covers the cycle before busy rises
	assign cmd_go = wr_cmd & ~active;
	assign count_zero = (count_q[`BLIT_COUNT_W-1:0] == '0) |
		(count_q[2*`BLIT_COUNT_W-1:`BLIT_COUNT_W] == '0);
	assign wval = s_wdata & wmask;

	always_comb begin
		for (int i = 0; i < `BLIT_DATA_W/8; i++) begin
			wmask[8*i +: 8] = {8{s_wstrb[i]}};
		end
	end

	always_comb begin
		rd_mux = '0;
		case (s_araddr)
			`BLIT_REG_SRC: rd_mux = src_q;
			`BLIT_REG_DST: rd_mux = dst_q;
			`BLIT_REG_PITCH: rd_mux = pitch_q;
			`BLIT_REG_COUNT: rd_mux = count_q;
			`BLIT_REG_CMD: begin
				rd_mux[`BLIT_CMD_SRCEN] = cmd.srcen;
				rd_mux[`BLIT_CMD_DSTEN] = cmd.dsten;
				rd_mux[`BLIT_CMD_LFU_LSB +: `BLIT_LFU_W] = cmd.lfu_func;
			end
			`BLIT_REG_STATUS: begin
				rd_mux[`BLIT_STAT_IDLE] = ~active;
				rd_mux[`BLIT_STAT_INT] = blit_int;
			end
			default: rd_mux = '0; // Unmapped reads as zero
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s_bvalid <= 1'b0;
			s_rvalid <= 1'b0;
			start <= 1'b0;
			zero_done <= 1'b0;
			blit_int <= 1'b0;
		end else begin
			start <= cmd_go & ~count_zero;
			zero_done <= cmd_go & count_zero; // Empty blit finishes here
			if (aw_hs)
				s_bvalid <= 1'b1;
			else if (s_bready)
				s_bvalid <= 1'b0;
			if (ar_hs)
				s_rvalid <= 1'b1;
			else if (s_rready)
				s_rvalid <= 1'b0;
			if (done | zero_done)
				blit_int <= 1'b1;
			else if (cmd_go)
				blit_int <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs) begin
			s_bresp <= (wr_cmd & active) ? `BLIT_RESP_SLVERR : `BLIT_RESP_OKAY;
			case (s_awaddr)
				`BLIT_REG_SRC: src_q <= merge(src_q, s_wdata, wmask);
				`BLIT_REG_DST: dst_q <= merge(dst_q, s_wdata, wmask);
				`BLIT_REG_PITCH: pitch_q <= merge(pitch_q, s_wdata, wmask);
				`BLIT_REG_COUNT: count_q <= merge(count_q, s_wdata, wmask);
				default: ;
			endcase
		end
		if (cmd_go) begin // Snapshot keeps cmd stable for the whole blit
			cmd.srcen <= wval[`BLIT_CMD_SRCEN];
			cmd.dsten <= wval[`BLIT_CMD_DSTEN];
			cmd.lfu_func <= wval[`BLIT_CMD_LFU_LSB +: `BLIT_LFU_W];
			cmd.src_base <= src_q[`BLIT_ADDR_W-1:0];
			cmd.dst_base <= dst_q[`BLIT_ADDR_W-1:0];
			cmd.pitch <= pitch_q[`BLIT_COUNT_W-1:0];
			cmd.inner_cnt <= count_q[`BLIT_COUNT_W-1:0];
			cmd.outer_cnt <= count_q[2*`BLIT_COUNT_W-1:`BLIT_COUNT_W];
		end
		if (ar_hs)
			s_rdata <= rd_mux;
	end

endmodule

// File: blit_state.sv
`timescale 1ns/100ps
`include "blit_cfg.svh"

module blit_state (
	input logic clk,
	input logic rst_n,
	input logic [`BLIT_REG_AW-1:0] s_awaddr,
	input logic s_awvalid,
	output logic s_awready,
	input logic [`BLIT_DATA_W-1:0] s_wdata,
	input logic [`BLIT_DATA_W/8-1:0] s_wstrb,
	input logic s_wvalid,
	output logic s_wready,
	output logic [1:0] s_bresp,
	output logic s_bvalid,
	input logic s_bready,
	input logic [`BLIT_REG_AW-1:0] s_araddr,
	input logic s_arvalid,
	output logic s_arready,
	output logic [`BLIT_DATA_W-1:0] s_rdata,
	output logic [1:0] s_rresp,
	output logic s_rvalid,
	input logic s_rready,
	output logic mreq,
	output blit_pkg::blit_cycle_t mem,
	input logic ack,
	input logic [`BLIT_DATA_W-1:0] rdata,
	output logic blit_int
);
	import blit_pkg::*;

	blit_cmd_t cmd; // Latched command
	logic start;
	logic busy;
	logic done;
	logic row_start;
	blit_row_t row; // Current row start
	logic row_done;
	logic cyc_valid;
	blit_cycle_t cyc; // Pending memory cycle
	logic cyc_done;
	logic [`BLIT_DATA_W-1:0] cyc_rdata;

	// GPU register port, status and interrupt
	blit_regs regs_i (.*);

	// Rows
	blit_outer outer_i (.*);

	// Pixels and logic function
	blit_inner inner_i (.*);

	// Memory handshake
	blit_mcontrol mcontrol_i (.*);

endmodule

// File: tb_blit.sv
`timescale 1ns/100ps
`include "blit_cfg.svh"

module tb_blit;
	import blit_pkg::*;

	localparam int PIXELS = 5 * 3 + 6 * 4 + 4 * 2; // Copy, XOR and completion blits
	localparam int CYCLE_LIMIT = PIXELS * 3 * 6 + 2000;

	logic clk;
	logic rst_n;
	logic [`BLIT_REG_AW-1:0] s_awaddr;
	logic s_awvalid;
	logic s_awready;
	logic [`BLIT_DATA_W-1:0] s_wdata;
	logic [`BLIT_DATA_W/8-1:0] s_wstrb;
	logic s_wvalid;
	logic s_wready;
	logic [1:0] s_bresp;
	logic s_bvalid;
	logic s_bready;
	logic [`BLIT_REG_AW-1:0] s_araddr;
	logic s_arvalid;
	logic s_arready;
	logic [`BLIT_DATA_W-1:0] s_rdata;
	logic [1:0] s_rresp;
	logic s_rvalid;
	logic s_rready;
	logic mreq;
	blit_cycle_t mem;
	logic ack;
	logic [`BLIT_DATA_W-1:0] rdata;
	logic blit_int;
	logic [7:0] test_id; // Names the running test for the checker
	int err_count;
	int check_count;
	int exp_left;
	int late_errors = 0;
	int cycles = 0;
	logic [16:0] lfsr_q;
	logic ack_random; // Random ack delay when set, else immediate

	blit_state dut_i (.*);
	blit_checker chk_i (.*);

	always #4 clk = ~clk;

	// Fibonacci LFSR, taps 17 and 14, one step per bit
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_q[16] ^ lfsr_q[13];
		lfsr_q = {lfsr_q[15:0], fb};
		return fb;
	endfunction

	function automatic logic [`BLIT_DATA_W-1:0] fill_word(input logic [`BLIT_ADDR_W-1:0] addr);
		return {addr[7:0] ^ addr[23:16], addr} ^ 32'h5a3c_96e1; // Every address bit shows
	endfunction

	task automatic axi_write(input logic [`BLIT_REG_AW-1:0] addr, input logic [31:0] data);
		@(posedge clk);
		#1;
		s_awaddr = addr;
		s_awvalid = 1'b1;
		s_wdata = data;
		s_wstrb = '1;
		s_wvalid = 1'b1;
		@(posedge clk);
		while (!(s_awready && s_wready)) begin
			@(posedge clk);
		end
		#1;
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		while (!s_bvalid) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk); // One cycle of back-pressure on B
		#1;
		s_bready = 1'b1;
		@(posedge clk);
		#1;
		s_bready = 1'b0;
	endtask

	task automatic axi_read(input logic [`BLIT_REG_AW-1:0] addr);
		@(posedge clk);
		#1;
		s_araddr = addr;
		s_arvalid = 1'b1;
		while (!s_arready) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		s_arvalid = 1'b0;
		s_rready = 1'b1;
		while (!s_rvalid) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		s_rready = 1'b0;
	endtask

	task automatic wait_for_irq();
		while (!blit_int) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Memory model, acks after 0 to 3 idle cycles
	initial begin : memory_model
		int delay_left;
		logic waiting;
		delay_left = 0;
		waiting = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (ack) begin
				ack = 1'b0; // Cycle completed at the edge just passed
				rdata = '0;
			end else if (mreq && rst_n) begin
				if (!waiting) begin
					waiting = 1'b1;
					delay_left = 0;
					if (ack_random) begin
						delay_left = 2 * lfsr_bit();
						delay_left = delay_left + lfsr_bit();
					end
				end
				if (delay_left == 0) begin
					ack = 1'b1;
					rdata = mem.rd ? fill_word(mem.addr) : '0;
					waiting = 1'b0;
				end else begin
					delay_left--;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		s_awaddr = '0;
		s_awvalid = 1'b0;
		s_wdata = '0;
		s_wstrb = '0;
		s_wvalid = 1'b0;
		s_bready = 1'b0;
		s_araddr = '0;
		s_arvalid = 1'b0;
		s_rready = 1'b0;
		ack = 1'b0;
		rdata = '0;
		lfsr_q = 17'd80959;
		ack_random = 1'b0;
		test_id = 8'd0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		test_id = 8'd1; // Register readback
		axi_write(`BLIT_REG_SRC, 32'h0012_3400);
		axi_write(`BLIT_REG_DST, 32'h0045_6800);
		axi_write(`BLIT_REG_PITCH, 32'h0000_0040);
		axi_write(`BLIT_REG_COUNT, {16'd3, 16'd5});
		axi_read(`BLIT_REG_SRC);
		axi_read(`BLIT_REG_DST);
		axi_read(`BLIT_REG_PITCH);
		axi_read(`BLIT_REG_COUNT);

		test_id = 8'd2; // Copy, source only
		axi_write(`BLIT_REG_CMD, (32'hc << `BLIT_CMD_LFU_LSB) | 32'h1);
		wait_for_irq();
		axi_read(`BLIT_REG_STATUS);

		test_id = 8'd3; // XOR of source and destination, source rows wrap
		axi_write(`BLIT_REG_SRC, 32'h00ff_fff0);
		axi_write(`BLIT_REG_DST, 32'h0020_0000);
		axi_write(`BLIT_REG_PITCH, 32'h0000_0010);
		axi_write(`BLIT_REG_COUNT, {16'd4, 16'd6});
		ack_random = 1'b1;
		axi_write(`BLIT_REG_CMD, (32'h6 << `BLIT_CMD_LFU_LSB) | 32'h3);
		wait_for_irq();
		ack_random = 1'b0;
		axi_read(`BLIT_REG_STATUS);

		test_id = 8'd4; // Completion, second command while busy
		axi_write(`BLIT_REG_COUNT, {16'd2, 16'd4});
		axi_write(`BLIT_REG_CMD, (32'h9 << `BLIT_CMD_LFU_LSB) | 32'h3);
		axi_write(`BLIT_REG_CMD, (32'hc << `BLIT_CMD_LFU_LSB) | 32'h1);
		axi_read(`BLIT_REG_STATUS);
		axi_read(`BLIT_REG_CMD);
		wait_for_irq();
		axi_read(`BLIT_REG_STATUS);

		test_id = 8'd5; // Zero inner count
		axi_write(`BLIT_REG_COUNT, {16'd2, 16'd0});
		axi_write(`BLIT_REG_CMD, (32'hc << `BLIT_CMD_LFU_LSB) | 32'h1);
		wait_for_irq();
		axi_read(`BLIT_REG_STATUS);
		axi_read(`BLIT_REG_COUNT);

		repeat (4) @(posedge clk);
		if (exp_left != 0) begin
			$display("%0d expected memory cycles were never issued", exp_left);
			late_errors++;
		end
		$display("checks %0d, errors %0d", check_count, err_count + late_errors);
		if (err_count + late_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+.
blit_pkg.sv
blit_regs.sv
blit_outer.sv
blit_inner.sv
blit_mcontrol.sv
blit_state.sv
blit_properties.sv
blit_checker.sv
tb_blit.sv
